//--- build.f
rv32_pkg.sv
decode.sv
reg_file.sv
execute.sv
data_mem.sv
writeback.sv
rv32_exec_top.sv
tb_rv32_exec.sv

//--- Makefile
TOP = tb_rv32_exec

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -f build.f --top-module $(TOP) -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

//--- tb_rv32_exec.sv
`default_nettype none
`timescale 1ns/1ps

module tb_rv32_exec;

    typedef logic [rv32_pkg::LEN_WORD-1:0]     word_t;
    typedef logic [rv32_pkg::LEN_REG_ADDR-1:0] ridx_t;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  inst_valid;
    word_t inst;
    word_t pc;
    logic  retire;
    logic  wb_en;
    ridx_t wb_rd;
    word_t wb_data;
    word_t next_pc;
    word_t xreg [32] = '{default: '0};   // Expected register file contents
    logic  chained = 1'b0;               // Previous strobe was in the last cycle
    int    errors = 0;
    int    checks = 0;

    rv32_exec_top uut (.*);

    always #5 clk = ~clk;

    function automatic word_t i_type(logic [11:0] imm, ridx_t rs1, logic [2:0] f3, ridx_t rd,
                                     logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t alu_model(logic [2:0] f3, word_t a, word_t b, logic alt);
        word_t sra;
        sra = $signed(a) >>> b[4:0];
        case (f3)
            rv32_pkg::F3_ADD:  return alt ? a - b : a + b;
            rv32_pkg::F3_SLL:  return a << b[4:0];
            rv32_pkg::F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
            rv32_pkg::F3_SLTU: return {31'b0, a < b};
            rv32_pkg::F3_XOR:  return a ^ b;
            rv32_pkg::F3_SR:   return alt ? sra : a >> b[4:0];
            rv32_pkg::F3_OR:   return a | b;
            default:           return a & b;
        endcase
    endfunction

    // Bit 2 picks the ordered compares, bit 1 the unsigned ones, bit 0 inverts
    function automatic logic br_model(logic [2:0] f3, word_t a, word_t b);
        logic lt;
        lt = f3[1] ? (a < b) : ($signed(a) < $signed(b));
        return f3[2] ? (lt ^ f3[0]) : ((a == b) ^ f3[0]);
    endfunction

    task automatic check_wb(logic en, ridx_t rd, word_t data);
        checks++;
        if (wb_en !== en || (en && (wb_rd !== rd || wb_data !== data))) begin
            errors++;
            $display("FAILED wb_en/wb_rd/wb_data: got %h/%h/%h expected %h/%h/%h",
                     wb_en, wb_rd, wb_data, en, rd, data);
        end
        if (en) begin
            xreg[rd] = data;   // Later operands read this value
        end
    endtask

    task automatic check_pc(word_t exp);
        checks++;
        if (next_pc !== exp) begin
            errors++;
            $display("FAILED next_pc: got %h expected %h", next_pc, exp);
        end
    endtask

    task automatic exec_inst(word_t i, word_t p, logic hold = 1'b0);
        int n = 0;
        @(negedge clk);
        checks++;
        if (retire && !chained) begin
            errors++;
            $display("Retire stayed high for more than one cycle before instruction %h", i);
        end
        chained    = hold;
        inst_valid = 1'b1;
        inst       = i;
        pc         = p;
        if (!hold) begin
            @(negedge clk);
            inst_valid = 1'b0;
            while (!retire && n < 8) begin
                @(negedge clk);
                n++;
            end
            if (!retire) begin
                errors++;
                $display("Timeout: no retire pulse for instruction %h", i);
            end
        end
    endtask

    task automatic load_reg(ridx_t rd);
        logic [11:0] imm;
        imm = 12'($urandom);
        exec_inst(i_type(imm, 5'd0, rv32_pkg::F3_ADD, rd, rv32_pkg::OP_ALUI), 32'h100);
        check_wb(1'b1, rd, {{20{imm[11]}}, imm});
    endtask

    task automatic alu_ops();
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        load_reg(5'd1);
        load_reg(5'd2);
        for (int k = 0; k < 10; k++) begin
            f3  = (k == 9) ? rv32_pkg::F3_SR : 3'(k);   // Entries 8 and 9 are SUB and SRA
            alt = (k >= 8);
            imm = 12'($urandom);
            exec_inst({1'b0, alt, 5'b0, 5'd2, 5'd1, f3, 5'd3, rv32_pkg::OP_ALU}, 32'h200);
            check_wb(1'b1, 5'd3, alu_model(f3, xreg[1], xreg[2], alt));
            if (f3 == rv32_pkg::F3_SLL || f3 == rv32_pkg::F3_SR) begin
                imm[11:5] = {1'b0, alt, 5'b0};   // Shift immediates carry func7
            end
            if (k != 8) begin
                exec_inst(i_type(imm, 5'd1, f3, 5'd4, rv32_pkg::OP_ALUI), 32'h204);
                check_wb(1'b1, 5'd4, alu_model(f3, xreg[1], {{20{imm[11]}}, imm}, alt));
            end
        end
    endtask

    task automatic zero_reg();
        exec_inst(i_type(12'h7ff, 5'd1, rv32_pkg::F3_ADD, 5'd0, rv32_pkg::OP_ALUI), 32'h300);
        check_wb(1'b0, 5'd0, '0);
        exec_inst({7'b0, 5'd1, 5'd0, rv32_pkg::F3_ADD, 5'd5, rv32_pkg::OP_ALU}, 32'h304);
        check_wb(1'b1, 5'd5, xreg[1]);   // x0 as rs1 adds nothing
    endtask

    task automatic upper_imm();
        logic [19:0] up;
        word_t       p;
        up = 20'($urandom);
        p  = $urandom & 32'hffff_fffc;
        exec_inst({up, 5'd6, rv32_pkg::OP_LUI}, p);
        check_wb(1'b1, 5'd6, {up, 12'b0});
        check_pc(p + 4);
        exec_inst({up, 5'd7, rv32_pkg::OP_AUIPC}, p);
        check_wb(1'b1, 5'd7, {up, 12'b0} + p);
        check_pc(p + 4);
    endtask

    task automatic branches();
        logic [12:0] off;
        logic [2:0]  f3;
        word_t       p;
        for (int k = 0; k < 12; k++) begin
            f3  = 3'(k / 2 + ((k >= 4) ? 2 : 0));
            off = 13'($urandom) & 13'h1ffe;
            p   = $urandom & 32'hffff_fffc;
            load_reg(5'd8);
            if (k[0]) begin
                exec_inst(i_type(12'd0, 5'd8, rv32_pkg::F3_ADD, 5'd9, rv32_pkg::OP_ALUI), p);
                check_wb(1'b1, 5'd9, xreg[8]);
            end else begin
                load_reg(5'd9);
            end
            exec_inst({off[12], off[10:5], 5'd9, 5'd8, f3, off[4:1], off[11],
                       rv32_pkg::OP_BRANCH}, p);
            check_wb(1'b0, 5'd0, '0);
            check_pc(br_model(f3, xreg[8], xreg[9]) ? p + {{19{off[12]}}, off} : p + 4);
        end
    endtask

    task automatic jumps();
        logic [20:0] off;
        logic [11:0] imm;
        word_t       p;
        off = 21'($urandom) & 21'h1ffffe;
        imm = 12'($urandom);
        p   = $urandom & 32'hffff_fffc;
        exec_inst({off[20], off[10:1], off[11], off[19:12], 5'd10, rv32_pkg::OP_JAL}, p);
        check_wb(1'b1, 5'd10, p + 4);
        check_pc(p + {{11{off[20]}}, off});
        exec_inst(i_type(imm, 5'd1, 3'b000, 5'd11, rv32_pkg::OP_JALR), p);
        check_wb(1'b1, 5'd11, p + 4);
        check_pc((xreg[1] + {{20{imm[11]}}, imm}) & ~32'h1);
    endtask

    task automatic store_load();
        word_t       data [4];
        logic [11:0] o;
        for (int k = 0; k < 4; k++) begin
            o = 12'(k * 36);
            load_reg(5'd13);
            data[k] = xreg[13];
            exec_inst({o[11:5], 5'd13, 5'd0, 3'b010, o[4:0], rv32_pkg::OP_MEMS}, 32'h500);
            check_wb(1'b0, 5'd0, '0);
        end
        for (int k = 0; k < 4; k++) begin
            o = 12'(k * 36);
            exec_inst(i_type(o, 5'd0, 3'b010, 5'd14, rv32_pkg::OP_MEML), 32'h504);
            check_wb(1'b1, 5'd14, data[k]);
        end
        load_reg(5'd13);
        // The load is strobed in the cycle right after the store
        exec_inst({7'd2, 5'd13, 5'd0, 3'b010, 5'd0, rv32_pkg::OP_MEMS}, 32'h508, 1'b1);
        exec_inst(i_type(12'd64, 5'd0, 3'b010, 5'd15, rv32_pkg::OP_MEML), 32'h50c);
        check_wb(1'b1, 5'd15, xreg[13]);
    endtask

    initial begin
        void'($urandom(32'hd61d));
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_wb(1'b0, 5'd0, '0);
        check_pc('0);
        alu_ops();
        zero_reg();
        upper_imm();
        branches();
        jumps();
        store_load();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv32_exec_top.sv
`default_nettype none
`timescale 1ns/1ps

module rv32_exec_top (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                inst_valid,
    input  wire [rv32_pkg::LEN_INST-1:0]       inst,
    input  wire [rv32_pkg::LEN_WORD-1:0]       pc,
    output logic                               retire,
    output logic                               wb_en,
    output logic [rv32_pkg::LEN_REG_ADDR-1:0]  wb_rd,
    output logic [rv32_pkg::LEN_WORD-1:0]      wb_data,
    output logic [rv32_pkg::LEN_WORD-1:0]      next_pc
);

    logic [rv32_pkg::LEN_REG_ADDR-1:0] rs1_addr;
    logic [rv32_pkg::LEN_REG_ADDR-1:0] rs2_addr;
    logic [rv32_pkg::LEN_WORD-1:0]     rs1_data;
    logic [rv32_pkg::LEN_WORD-1:0]     rs2_data;
    logic [rv32_pkg::LEN_WORD-1:0]     load_data;
    logic                              rf_we;
    logic [rv32_pkg::LEN_REG_ADDR-1:0] rf_wa;
    logic [rv32_pkg::LEN_WORD-1:0]     rf_wd;
    rv32_pkg::dec_t                    dec;
    rv32_pkg::exe_t                    exe;

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .we(rf_we), .wa(rf_wa), .wd(rf_wd)
    );

    decode u_decode (
        .inst(inst), .pc(pc),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .dec(dec)
    );

    execute u_execute (.dec(dec), .exe(exe));

    data_mem u_data_mem (
        .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid),
        .dec(dec), .load_data(load_data)
    );

    writeback u_writeback (
        .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid),
        .dec(dec), .exe(exe), .load_data(load_data),
        .rf_we(rf_we), .rf_wa(rf_wa), .rf_wd(rf_wd),
        .retire(retire), .wb_en(wb_en), .wb_rd(wb_rd),
        .wb_data(wb_data), .next_pc(next_pc)
    );

endmodule

`default_nettype wire

//--- writeback.sv
`default_nettype none
`timescale 1ns/1ps

module writeback (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                inst_valid,
    input  wire rv32_pkg::dec_t                dec,
    input  wire rv32_pkg::exe_t                exe,
    input  wire [rv32_pkg::LEN_WORD-1:0]       load_data,
    output logic                               rf_we,
    output logic [rv32_pkg::LEN_REG_ADDR-1:0]  rf_wa,
    output logic [rv32_pkg::LEN_WORD-1:0]      rf_wd,
    output logic                               retire,
    output logic                               wb_en,
    output logic [rv32_pkg::LEN_REG_ADDR-1:0]  wb_rd,
    output logic [rv32_pkg::LEN_WORD-1:0]      wb_data,
    output logic [rv32_pkg::LEN_WORD-1:0]      next_pc
);

    logic                          is_load;
    logic                          writes;
    logic [rv32_pkg::LEN_WORD-1:0] seq_pc;

    assign is_load = dec.mem && !dec.store;
    assign writes  = dec.alu || dec.subst || dec.jump || is_load;   // Unknown opcodes write nothing
    assign seq_pc  = dec.pc + 32'd4;

    assign rf_we = inst_valid && writes && (dec.rd != '0);
    assign rf_wa = dec.rd;
    assign rf_wd = is_load ? load_data : exe.value;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire  <= 1'b0;
            wb_en   <= 1'b0;
            next_pc <= '0;
        end else begin
            retire <= inst_valid;
            wb_en  <= rf_we;
            if (inst_valid) begin
                next_pc <= exe.taken ? exe.target : seq_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            wb_rd   <= dec.rd;
            wb_data <= rf_wd;
        end
    end

endmodule

`default_nettype wire

//--- data_mem.sv
`default_nettype none
`timescale 1ns/1ps

module data_mem (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           inst_valid,
    input  wire rv32_pkg::dec_t           dec,
    output logic [rv32_pkg::LEN_WORD-1:0] load_data
);

    logic [rv32_pkg::LEN_WORD-1:0]      mem [rv32_pkg::DMEM_DEPTH];
    logic [rv32_pkg::LEN_DMEM_ADDR-1:0] word_addr;
    logic                               wr_en;

    assign word_addr = dec.op_a[7:2];   // Byte address to word index
    assign wr_en     = inst_valid && dec.store;
    assign load_data = mem[word_addr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rv32_pkg::DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[word_addr] <= dec.op_b;
        end
    end

endmodule

`default_nettype wire

//--- execute.sv
`default_nettype none
`timescale 1ns/1ps

module execute (
    input  wire rv32_pkg::dec_t dec,
    output rv32_pkg::exe_t      exe
);

    logic [rv32_pkg::LEN_WORD-1:0] alu_out;
    logic [rv32_pkg::LEN_WORD-1:0] sra_out;
    logic [rv32_pkg::LEN_WORD-1:0] link;
    logic [4:0]                    shamt;
    logic                          arith;
    logic                          sub_en;
    logic                          cond;

    assign shamt   = dec.op_b[4:0];
    assign arith   = dec.func7[5];
    assign sub_en  = arith && (dec.opecode == rv32_pkg::OP_ALU);   // ADDI has no subtract form
    assign sra_out = $signed(dec.op_a) >>> shamt;
    assign link    = dec.pc + 32'd4;

    always_comb begin
        case (dec.func3)
            rv32_pkg::F3_ADD:  alu_out = sub_en ? dec.op_a - dec.op_b : dec.op_a + dec.op_b;
            rv32_pkg::F3_SLL:  alu_out = dec.op_a << shamt;
            rv32_pkg::F3_SLT:  alu_out = {31'b0, $signed(dec.op_a) < $signed(dec.op_b)};
            rv32_pkg::F3_SLTU: alu_out = {31'b0, dec.op_a < dec.op_b};
            rv32_pkg::F3_XOR:  alu_out = dec.op_a ^ dec.op_b;
            rv32_pkg::F3_SR:   alu_out = arith ? sra_out : dec.op_a >> shamt;
            rv32_pkg::F3_OR:   alu_out = dec.op_a | dec.op_b;
            default:           alu_out = dec.op_a & dec.op_b;
        endcase
    end

    always_comb begin
        case (dec.func3)
            rv32_pkg::F3_BEQ:  cond = (dec.op_a == dec.op_b);
            rv32_pkg::F3_BNE:  cond = (dec.op_a != dec.op_b);
            rv32_pkg::F3_BLT:  cond = ($signed(dec.op_a) < $signed(dec.op_b));
            rv32_pkg::F3_BGE:  cond = ($signed(dec.op_a) >= $signed(dec.op_b));
            rv32_pkg::F3_BLTU: cond = (dec.op_a < dec.op_b);
            rv32_pkg::F3_BGEU: cond = (dec.op_a >= dec.op_b);
            default:           cond = 1'b0;   // Reserved encodings never branch
        endcase
    end

    always_comb begin
        exe = '0;
        if (dec.alu) begin
            exe.value = alu_out;
        end else if (dec.jump) begin
            exe.value  = link;
            exe.taken  = 1'b1;
            exe.target = {dec.op_a[rv32_pkg::LEN_WORD-1:1], 1'b0};
        end else if (dec.branch) begin
            exe.taken  = cond;
            exe.target = dec.op_c;
        end else if (dec.subst) begin
            exe.value = dec.op_c;
        end
    end

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire [rv32_pkg::LEN_REG_ADDR-1:0]   rs1_addr,
    input  wire [rv32_pkg::LEN_REG_ADDR-1:0]   rs2_addr,
    output logic [rv32_pkg::LEN_WORD-1:0]      rs1_data,
    output logic [rv32_pkg::LEN_WORD-1:0]      rs2_data,
    input  wire                                we,
    input  wire [rv32_pkg::LEN_REG_ADDR-1:0]   wa,
    input  wire [rv32_pkg::LEN_WORD-1:0]       wd
);

    logic [rv32_pkg::LEN_WORD-1:0] regs [32];

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];   // x0 is hardwired to zero
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

endmodule

`default_nettype wire

//--- decode.sv
`default_nettype none
`timescale 1ns/1ps

module decode (
    input  wire [rv32_pkg::LEN_INST-1:0]      inst,
    input  wire [rv32_pkg::LEN_WORD-1:0]      pc,
    output logic [rv32_pkg::LEN_REG_ADDR-1:0] rs1_addr,
    output logic [rv32_pkg::LEN_REG_ADDR-1:0] rs2_addr,
    input  wire [rv32_pkg::LEN_WORD-1:0]      rs1_data,
    input  wire [rv32_pkg::LEN_WORD-1:0]      rs2_data,
    output rv32_pkg::dec_t                    dec
);

    logic [rv32_pkg::LEN_OPECODE-1:0] opecode;
    logic [rv32_pkg::LEN_WORD-1:0]    imm_i;
    logic [rv32_pkg::LEN_WORD-1:0]    imm_s;
    logic [rv32_pkg::LEN_WORD-1:0]    imm_b;
    logic [rv32_pkg::LEN_WORD-1:0]    imm_j;
    logic [rv32_pkg::LEN_WORD-1:0]    imm_u;

    assign opecode  = inst[6:0];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    // All immediates are sign extended from inst bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        dec         = '0;
        dec.opecode = opecode;
        dec.rd      = inst[11:7];
        dec.func3   = inst[14:12];
        dec.func7   = inst[31:25];
        dec.pc      = pc;

        dec.alu    = (opecode == rv32_pkg::OP_ALU) || (opecode == rv32_pkg::OP_ALUI);
        dec.mem    = (opecode == rv32_pkg::OP_MEML) || (opecode == rv32_pkg::OP_MEMS);
        dec.store  = (opecode == rv32_pkg::OP_MEMS);
        dec.jump   = (opecode == rv32_pkg::OP_JAL) || (opecode == rv32_pkg::OP_JALR);
        dec.branch = (opecode == rv32_pkg::OP_BRANCH);
        dec.subst  = (opecode == rv32_pkg::OP_LUI) || (opecode == rv32_pkg::OP_AUIPC);

        dec.op_a = rs1_data;
        dec.op_b = rs2_data;
        dec.op_c = imm_i;

        case (opecode)
            rv32_pkg::OP_ALUI: begin
                dec.op_b = imm_i;
            end
            rv32_pkg::OP_MEML: begin
                dec.op_a = rs1_data + imm_i;          // Byte address of the load
            end
            rv32_pkg::OP_MEMS: begin
                dec.op_a = rs1_data + imm_s;
            end
            rv32_pkg::OP_JALR: begin
                dec.op_a = rs1_data + imm_i;          // Bit 0 is cleared in execute
            end
            rv32_pkg::OP_JAL: begin
                dec.op_a = pc + imm_j;
            end
            rv32_pkg::OP_BRANCH: begin
                dec.op_c = pc + imm_b;                // Taken target
            end
            rv32_pkg::OP_LUI: begin
                dec.op_c = imm_u;
            end
            rv32_pkg::OP_AUIPC: begin
                dec.op_c = pc + imm_u;
            end
            default: begin
                dec.op_c = imm_i;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rv32_pkg.sv
`default_nettype none

package rv32_pkg;

    localparam int LEN_WORD      = 32;
    localparam int LEN_INST      = 32;
    localparam int LEN_REG_ADDR  = 5;
    localparam int LEN_OPECODE   = 7;
    localparam int LEN_FUNC3     = 3;
    localparam int LEN_FUNC7     = 7;
    localparam int DMEM_DEPTH    = 64;
    localparam int LEN_DMEM_ADDR = 6;

    localparam logic [LEN_OPECODE-1:0] OP_ALU    = 7'b0110011;
    localparam logic [LEN_OPECODE-1:0] OP_ALUI   = 7'b0010011;
    localparam logic [LEN_OPECODE-1:0] OP_MEML   = 7'b0000011;
    localparam logic [LEN_OPECODE-1:0] OP_MEMS   = 7'b0100011;
    localparam logic [LEN_OPECODE-1:0] OP_JAL    = 7'b1101111;
    localparam logic [LEN_OPECODE-1:0] OP_JALR   = 7'b1100111;
    localparam logic [LEN_OPECODE-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [LEN_OPECODE-1:0] OP_LUI    = 7'b0110111;
    localparam logic [LEN_OPECODE-1:0] OP_AUIPC  = 7'b0010111;

    localparam logic [LEN_FUNC3-1:0] F3_ADD  = 3'b000;
    localparam logic [LEN_FUNC3-1:0] F3_SLL  = 3'b001;
    localparam logic [LEN_FUNC3-1:0] F3_SLT  = 3'b010;
    localparam logic [LEN_FUNC3-1:0] F3_SLTU = 3'b011;
    localparam logic [LEN_FUNC3-1:0] F3_XOR  = 3'b100;
    localparam logic [LEN_FUNC3-1:0] F3_SR   = 3'b101; // SRL or SRA by func7 bit 5
    localparam logic [LEN_FUNC3-1:0] F3_OR   = 3'b110;
    localparam logic [LEN_FUNC3-1:0] F3_AND  = 3'b111;

    localparam logic [LEN_FUNC3-1:0] F3_BEQ  = 3'b000;
    localparam logic [LEN_FUNC3-1:0] F3_BNE  = 3'b001;
    localparam logic [LEN_FUNC3-1:0] F3_BLT  = 3'b100;
    localparam logic [LEN_FUNC3-1:0] F3_BGE  = 3'b101;
    localparam logic [LEN_FUNC3-1:0] F3_BLTU = 3'b110;
    localparam logic [LEN_FUNC3-1:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic                    alu;
        logic                    mem;
        logic                    jump;
        logic                    branch;
        logic                    subst;   // LUI and AUIPC
        logic                    store;
        logic [LEN_WORD-1:0]     op_a;
        logic [LEN_WORD-1:0]     op_b;
        logic [LEN_WORD-1:0]     op_c;    // Immediate or precomputed target
        logic [LEN_REG_ADDR-1:0] rd;
        logic [LEN_OPECODE-1:0]  opecode;
        logic [LEN_FUNC3-1:0]    func3;
        logic [LEN_FUNC7-1:0]    func7;
        logic [LEN_WORD-1:0]     pc;
    } dec_t;

    typedef struct packed {
        logic [LEN_WORD-1:0] value;
        logic                taken;   // Control leaves sequential flow
        logic [LEN_WORD-1:0] target;
    } exe_t;

endpackage

`default_nettype wire
